//--- source/lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, command encoding and payload structs of the LSU
// modules pull this in with a wildcard import in their body
//////////////////////////////////////////////////////////////////////

package lsu_pkg;

  // data and address width, one word
  localparam int xlen   = 32;
  // byte lanes per word
  localparam int nbytes = 4;
  // register file address width
  localparam int ralen  = 5;

  // command encoding
  // bit 3 write, bit 2 unsigned load, bit 1 word, bit 0 half
  typedef enum logic [3:0] {
    lsu_load_byte    = 4'b0000,
    lsu_load_half    = 4'b0001,
    lsu_load_word    = 4'b0010,
    lsu_load_byte_u  = 4'b0100,
    lsu_load_half_u  = 4'b0101,
    lsu_store_byte   = 4'b1000,
    lsu_store_half   = 4'b1001,
    lsu_store_word   = 4'b1010
  } lsu_cmd_e;

  // command as handed over by the core
  typedef struct packed {
    lsu_cmd_e          cmd;
    logic [xlen-1:0]   addr;
    logic [xlen-1:0]   data;
    logic [ralen-1:0]  regdest;
  } lsu_req_t;

  // request toward the data RAM, store data already in lane position
  typedef struct packed {
    logic [xlen-1:0]   addr;
    logic [xlen-1:0]   data;
    logic [nbytes-1:0] strobe;
    logic              write;
  } mem_req_t;

  // answer from the data RAM
  typedef struct packed {
    logic [xlen-1:0]   data;
    logic              error;
  } mem_rsp_t;

  // record kept for every request that went to memory
  // addr picks the load lane and is the reported error address
  typedef struct packed {
    lsu_cmd_e          cmd;
    logic [ralen-1:0]  regdest;
    logic [xlen-1:0]   addr;
  } inflight_t;

endpackage

//--- source/lsu_skid_buffer.sv
//////////////////////////////////////////////////////////////////////
// two-entry valid/ready skid buffer with registered output and
// registered input ready, payload type set per instance
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     out_valid_q, out_valid_d;
  logic     skid_valid_q, skid_valid_d;
  logic     in_ready_q;
  logic     in_fire, out_free;
  payload_t out_data_q, skid_data_q;

  assign in_fire  = in_valid_i && in_ready_q;
  // output register can take a new entry this cycle
  assign out_free = out_ready_i || !out_valid_q;

  always_comb begin
    out_valid_d  = out_valid_q;
    skid_valid_d = skid_valid_q;
    if (out_free) begin
      // skid entry drains first, otherwise input goes straight to output
      out_valid_d  = skid_valid_q || in_fire;
      skid_valid_d = 1'b0;
    end else if (in_fire) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      in_ready_q   <= 1'b0;
    end else begin
      out_valid_q  <= out_valid_d;
      skid_valid_q <= skid_valid_d;
      // ready only while the skid entry is empty
      in_ready_q   <= !skid_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      if (skid_valid_q) begin
        out_data_q <= skid_data_q;
      end else if (in_fire) begin
        out_data_q <= in_data_i;
      end
    end else if (in_fire) begin
      skid_data_q <= in_data_i;
    end
  end

  assign in_ready_o  = in_ready_q;
  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

  // a stalled output holds its payload until taken
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));

endmodule

//--- source/lsu_issue.sv
//////////////////////////////////////////////////////////////////////
// LSU input side: alignment check, request buffering, strobe and lane
// placement toward the data RAM, and the core stall during loads
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_issue (
  input  logic                     clk_i,
  input  logic                     rstn_i,
  input  logic                     lsu_valid_i,
  output logic                     lsu_ready_o,
  input  lsu_pkg::lsu_req_t        lsu_req_i,
  output lsu_pkg::mem_req_t        mem_req_o,
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output lsu_pkg::inflight_t       inflight_o,
  output logic                     inflight_valid_o,
  input  logic                     load_retired_i,
  output logic                     misaligned_load_o,
  output logic                     misaligned_store_o,
  output logic [lsu_pkg::xlen-1:0] misaligned_addr_o
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_run,        // accepting commands
    st_load_wait,  // load outstanding, core stalled
    st_full        // request buffer full
  } state_e;

  state_e            state_q, state_d;
  logic              lsu_fire, aligned, is_write;
  logic              buf_in_ready, mem_fire;
  lsu_req_t          buf_req;
  logic [nbytes-1:0] base_strobe;
  logic              misaligned_load_q, misaligned_store_q;
  logic [xlen-1:0]   misaligned_addr_q;

  assign lsu_fire = lsu_valid_i && lsu_ready_o;
  assign is_write = lsu_req_i.cmd[3];

  // word needs addr[1:0] == 0, half needs an even address
  always_comb begin
    aligned = 1'b1;
    if (lsu_req_i.cmd[1]) begin
      aligned = (lsu_req_i.addr[1:0] == 2'b00);
    end else if (lsu_req_i.cmd[0]) begin
      aligned = !lsu_req_i.addr[0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request buffer and memory side
  //////////////////////////////////////////////////////////////////////

  // misaligned commands are accepted but never enter the buffer
  lsu_skid_buffer #(
    .payload_t (lsu_pkg::lsu_req_t)
  ) i_req_buf (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (lsu_fire && aligned),
    .in_ready_o  (buf_in_ready),
    .in_data_i   (lsu_req_i),
    .out_valid_o (mem_req_valid_o),
    .out_ready_i (mem_req_ready_i),
    .out_data_o  (buf_req)
  );

  always_comb begin
    // byte always, half adds lane 1, word adds lanes 2 and 3
    base_strobe      = {buf_req.cmd[1], buf_req.cmd[1], buf_req.cmd[1] | buf_req.cmd[0], 1'b1};
    mem_req_o.addr   = buf_req.addr;
    mem_req_o.data   = buf_req.data << {buf_req.addr[1:0], 3'b000};
    mem_req_o.strobe = base_strobe << buf_req.addr[1:0];
    mem_req_o.write  = buf_req.cmd[3];
  end

  // every request that fires leaves a record for the retire side
  assign mem_fire         = mem_req_valid_o && mem_req_ready_i;
  assign inflight_valid_o = mem_fire;

  always_comb begin
    inflight_o.cmd     = buf_req.cmd;
    inflight_o.regdest = buf_req.regdest;
    inflight_o.addr    = buf_req.addr;
  end

  //////////////////////////////////////////////////////////////////////
  // stall FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_run: begin
        if (lsu_fire && aligned && !is_write) begin
          state_d = st_load_wait;
        end else if (!buf_in_ready) begin
          state_d = st_full;
        end
      end
      st_load_wait: begin
        if (load_retired_i) begin
          state_d = st_run;
        end
      end
      st_full: begin
        if (buf_in_ready) begin
          state_d = st_run;
        end
      end
      default: state_d = st_run;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= st_run;
    end else begin
      state_q <= state_d;
    end
  end

  assign lsu_ready_o = (state_q == st_run) && buf_in_ready;

  // one-cycle misaligned pulse
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      misaligned_load_q  <= 1'b0;
      misaligned_store_q <= 1'b0;
    end else begin
      misaligned_load_q  <= lsu_fire && !aligned && !is_write;
      misaligned_store_q <= lsu_fire && !aligned && is_write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu_fire && !aligned) begin
      misaligned_addr_q <= lsu_req_i.addr;
    end
  end

  assign misaligned_load_o  = misaligned_load_q;
  assign misaligned_store_o = misaligned_store_q;
  assign misaligned_addr_o  = misaligned_addr_q;

  // no command gets in while a load is at the RAM port or retiring
  a_no_accept_in_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
    ((mem_req_valid_o && !mem_req_o.write) || load_retired_i) |-> !lsu_fire);

  // retire only reports loads that this side is waiting on
  a_retire_in_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
    load_retired_i |-> (state_q == st_load_wait));

endmodule

//--- source/lsu_data_ram.sv
//////////////////////////////////////////////////////////////////////
// word-wide data RAM with byte strobes, answers one cycle after each
// accepted request, error for addresses past the configured depth
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_data_ram #(
  parameter int ram_depth_words = 256
) (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  lsu_pkg::mem_req_t mem_req_i,
  input  logic              mem_req_valid_i,
  output logic              mem_req_ready_o,
  output lsu_pkg::mem_rsp_t mem_rsp_o,
  output logic              mem_rsp_valid_o
);
  import lsu_pkg::*;

  localparam int idx_w = (ram_depth_words > 1) ? $clog2(ram_depth_words) : 1;

  logic [xlen-1:0]  mem_q [ram_depth_words];
  logic             ready_q, rsp_valid_q;
  logic             req_fire, in_range;
  logic [idx_w-1:0] word_idx;
  mem_rsp_t         rsp_q;

  assign req_fire = mem_req_valid_i && ready_q;
  // byte address must stay below depth * 4
  assign in_range = mem_req_i.addr[xlen-1:2] < (xlen-2)'(ram_depth_words);
  assign word_idx = mem_req_i.addr[idx_w+1:2];

  // byte-enabled write, out-of-range stores leave memory untouched
  always_ff @(posedge clk_i) begin
    if (req_fire && in_range && mem_req_i.write) begin
      for (int b = 0; b < nbytes; b++) begin
        if (mem_req_i.strobe[b]) begin
          mem_q[word_idx][8*b +: 8] <= mem_req_i.data[8*b +: 8];
        end
      end
    end
  end

  // full word comes back on reads, lane select is done on retire
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q.error <= !in_range;
      rsp_q.data  <= in_range ? mem_q[word_idx] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ready_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      ready_q     <= 1'b1;
      rsp_valid_q <= req_fire;
    end
  end

  assign mem_req_ready_o = ready_q;
  assign mem_rsp_o       = rsp_q;
  assign mem_rsp_valid_o = rsp_valid_q;

endmodule

//--- source/lsu_retire.sv
//////////////////////////////////////////////////////////////////////
// LSU output side: pairs RAM responses with in-flight records,
// extends load data for write-back and reports bus errors
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_retire (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  lsu_pkg::inflight_t        inflight_i,
  input  logic                      inflight_valid_i,
  output logic                      inflight_ready_o,
  input  lsu_pkg::mem_rsp_t         mem_rsp_i,
  input  logic                      mem_rsp_valid_i,
  output logic                      rf_wb_o,
  output logic [lsu_pkg::xlen-1:0]  rf_data_o,
  output logic [lsu_pkg::ralen-1:0] rf_dest_o,
  output logic                      load_retired_o,
  output logic                      bus_error_o,
  output logic [lsu_pkg::xlen-1:0]  bus_error_addr_o
);
  import lsu_pkg::*;

  inflight_t       rec, rec_q;
  logic            rec_valid;
  mem_rsp_t        rsp_q;
  logic            rsp_valid_q;
  logic            is_load;
  logic [xlen-1:0] lane_data;

  // lane data sits in the low bits, bit 2 of cmd selects zero extension
  function automatic logic [xlen-1:0] extend_load(input logic [xlen-1:0] d,
                                                  input lsu_cmd_e cmd);
    logic [xlen-1:0] ret;
    if (cmd[1]) begin
      ret = d;
    end else if (cmd[0]) begin
      ret = {{(xlen-16){d[15] & !cmd[2]}}, d[15:0]};
    end else begin
      ret = {{(xlen-8){d[7] & !cmd[2]}}, d[7:0]};
    end
    return ret;
  endfunction

  // oldest record pops together with its response
  lsu_skid_buffer #(
    .payload_t (lsu_pkg::inflight_t)
  ) i_inflight_buf (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (inflight_valid_i),
    .in_ready_o  (inflight_ready_o),
    .in_data_i   (inflight_i),
    .out_valid_o (rec_valid),
    .out_ready_i (mem_rsp_valid_i),
    .out_data_o  (rec)
  );

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= mem_rsp_valid_i;
    end
  end

  // response and its record registered as one pair
  always_ff @(posedge clk_i) begin
    if (mem_rsp_valid_i) begin
      rsp_q <= mem_rsp_i;
      rec_q <= rec;
    end
  end

  assign is_load   = !rec_q.cmd[3];
  // shift the addressed byte lane down to bit 0
  assign lane_data = rsp_q.data >> {rec_q.addr[1:0], 3'b000};

  assign rf_data_o        = extend_load(lane_data, rec_q.cmd);
  assign rf_dest_o        = rec_q.regdest;
  assign rf_wb_o          = rsp_valid_q && is_load && !rsp_q.error;
  // error loads release the core as well
  assign load_retired_o   = rsp_valid_q && is_load;
  assign bus_error_o      = rsp_valid_q && rsp_q.error;
  assign bus_error_addr_o = rec_q.addr;

  // every RAM response has a record from the issue side waiting
  a_no_ghost_rsp: assert property (@(posedge clk_i) disable iff (!rstn_i)
    mem_rsp_valid_i |-> rec_valid);

endmodule

//--- source/lsu_top.sv
//////////////////////////////////////////////////////////////////////
// LSU top level with its data RAM, core-side command port, register
// file write-back and exception reporting toward the controller
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_top #(
  parameter int ram_depth_words = 256
) (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      lsu_valid_i,
  output logic                      lsu_ready_o,
  input  lsu_pkg::lsu_req_t         lsu_req_i,
  output logic                      rf_wb_o,
  output logic [lsu_pkg::xlen-1:0]  rf_data_o,
  output logic [lsu_pkg::ralen-1:0] rf_dest_o,
  output logic                      ctrl_misaligned_load_o,
  output logic                      ctrl_misaligned_store_o,
  output logic                      ctrl_bus_error_o,
  output logic [lsu_pkg::xlen-1:0]  ctrl_exception_addr_o
);
  import lsu_pkg::*;

  mem_req_t        mem_req;
  logic            mem_req_valid, mem_req_ready;
  mem_rsp_t        mem_rsp;
  logic            mem_rsp_valid;
  inflight_t       inflight;
  logic            inflight_valid, inflight_ready;
  logic            load_retired;
  logic [xlen-1:0] misaligned_addr, bus_error_addr;

  lsu_issue i_issue (
    .clk_i              (clk_i),
    .rstn_i             (rstn_i),
    .lsu_valid_i        (lsu_valid_i),
    .lsu_ready_o        (lsu_ready_o),
    .lsu_req_i          (lsu_req_i),
    .mem_req_o          (mem_req),
    .mem_req_valid_o    (mem_req_valid),
    .mem_req_ready_i    (mem_req_ready),
    .inflight_o         (inflight),
    .inflight_valid_o   (inflight_valid),
    .load_retired_i     (load_retired),
    .misaligned_load_o  (ctrl_misaligned_load_o),
    .misaligned_store_o (ctrl_misaligned_store_o),
    .misaligned_addr_o  (misaligned_addr)
  );

  lsu_data_ram #(
    .ram_depth_words (ram_depth_words)
  ) i_data_ram (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .mem_req_i       (mem_req),
    .mem_req_valid_i (mem_req_valid),
    .mem_req_ready_o (mem_req_ready),
    .mem_rsp_o       (mem_rsp),
    .mem_rsp_valid_o (mem_rsp_valid)
  );

  lsu_retire i_retire (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .inflight_i       (inflight),
    .inflight_valid_i (inflight_valid),
    .inflight_ready_o (inflight_ready),
    .mem_rsp_i        (mem_rsp),
    .mem_rsp_valid_i  (mem_rsp_valid),
    .rf_wb_o          (rf_wb_o),
    .rf_data_o        (rf_data_o),
    .rf_dest_o        (rf_dest_o),
    .load_retired_o   (load_retired),
    .bus_error_o      (ctrl_bus_error_o),
    .bus_error_addr_o (bus_error_addr)
  );

  // misaligned belongs to the current command, so it wins over a
  // bus error from an older store
  assign ctrl_exception_addr_o = (ctrl_misaligned_load_o || ctrl_misaligned_store_o) ?
                                 misaligned_addr : bus_error_addr;

  // fixed RAM latency drains the record buffer at the issue rate
  a_inflight_accepted: assert property (@(posedge clk_i) disable iff (!rstn_i)
    inflight_valid |-> inflight_ready);

endmodule

//--- verif/lsu_tb.sv
//////////////////////////////////////////////////////////////////////
// directed testbench for the LSU top level with a byte-wide reference
// memory model, run with the file list in the project root
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int ram_depth_words = 256;
  localparam int mem_bytes       = ram_depth_words * 4;
  // fill, directed tests and 200 random commands
  localparam int n_cmds          = 520;
  localparam int timeout_cycles  = n_cmds * 20 + 500;
  // selectors for wait_event
  localparam int ev_wb           = 0;
  localparam int ev_bus_error    = 1;
  localparam int ev_ready        = 2;

  logic              clk_i;
  logic              rstn_i;
  logic              lsu_valid_i;
  logic              lsu_ready_o;
  lsu_req_t          lsu_req_i;
  logic              rf_wb_o;
  logic [xlen-1:0]   rf_data_o;
  logic [ralen-1:0]  rf_dest_o;
  logic              ctrl_misaligned_load_o;
  logic              ctrl_misaligned_store_o;
  logic              ctrl_bus_error_o;
  logic [xlen-1:0]   ctrl_exception_addr_o;

  // reference copy of the data RAM, one entry per byte
  logic [7:0]        ref_mem [mem_bytes];
  logic [31:0]       lcg_state;
  int                errors;
  int                checks;

  lsu_top #(
    .ram_depth_words (ram_depth_words)
  ) i_dut (
    .clk_i                   (clk_i),
    .rstn_i                  (rstn_i),
    .lsu_valid_i             (lsu_valid_i),
    .lsu_ready_o             (lsu_ready_o),
    .lsu_req_i               (lsu_req_i),
    .rf_wb_o                 (rf_wb_o),
    .rf_data_o               (rf_data_o),
    .rf_dest_o               (rf_dest_o),
    .ctrl_misaligned_load_o  (ctrl_misaligned_load_o),
    .ctrl_misaligned_store_o (ctrl_misaligned_store_o),
    .ctrl_bus_error_o        (ctrl_bus_error_o),
    .ctrl_exception_addr_o   (ctrl_exception_addr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic lsu_req_t make_req(input lsu_cmd_e cmd, input logic [xlen-1:0] addr,
                                        input logic [xlen-1:0] data,
                                        input logic [ralen-1:0] dest);
    lsu_req_t req;
    req.cmd     = cmd;
    req.addr    = addr;
    req.data    = data;
    req.regdest = dest;
    return req;
  endfunction

  function automatic lsu_cmd_e pick_cmd(input logic [2:0] sel);
    case (sel)
      3'd0:    return lsu_load_byte;
      3'd1:    return lsu_load_half;
      3'd2:    return lsu_load_word;
      3'd3:    return lsu_load_byte_u;
      3'd4:    return lsu_load_half_u;
      3'd5:    return lsu_store_byte;
      3'd6:    return lsu_store_half;
      default: return lsu_store_word;
    endcase
  endfunction

  // little-endian byte writes, width taken from the store kind
  function automatic void model_store(input lsu_cmd_e cmd, input logic [xlen-1:0] addr,
                                      input logic [xlen-1:0] data);
    logic [9:0] a;
    int         n;
    a = addr[9:0];
    n = (cmd == lsu_store_word) ? 4 : (cmd == lsu_store_half) ? 2 : 1;
    for (int i = 0; i < n; i++) begin
      ref_mem[a + 10'(i)] = data[8*i +: 8];
    end
  endfunction

  function automatic logic [xlen-1:0] model_load(input lsu_cmd_e cmd,
                                                 input logic [xlen-1:0] addr);
    logic [9:0]      a;
    logic [xlen-1:0] ret;
    a = addr[9:0];
    case (cmd)
      lsu_load_byte:   ret = {{24{ref_mem[a][7]}}, ref_mem[a]};
      lsu_load_byte_u: ret = {24'h0, ref_mem[a]};
      lsu_load_half:   ret = {{16{ref_mem[a + 10'd1][7]}}, ref_mem[a + 10'd1], ref_mem[a]};
      lsu_load_half_u: ret = {16'h0, ref_mem[a + 10'd1], ref_mem[a]};
      default: ret = {ref_mem[a + 10'd3], ref_mem[a + 10'd2], ref_mem[a + 10'd1], ref_mem[a]};
    endcase
    return ret;
  endfunction

  function automatic logic event_high(input int kind);
    case (kind)
      ev_wb:        return rf_wb_o;
      ev_bus_error: return ctrl_bus_error_o;
      default:      return lsu_ready_o;
    endcase
  endfunction

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_cmd(input lsu_req_t req, output int waited);
    waited      = 0;
    lsu_req_i   = req;
    lsu_valid_i = 1'b1;
    // ready comes from registers, so its value here holds at the next rising edge
    while (!lsu_ready_o) begin
      waited++;
      @(negedge clk_i);
    end
    @(negedge clk_i);
    lsu_valid_i = 1'b0;
  endtask

  task automatic wait_event(input int kind, input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit) begin
      if (event_high(kind)) begin
        seen = 1'b1;
      end else begin
        n++;
        @(negedge clk_i);
      end
    end
  endtask

  task automatic check_load(input string name, input logic [xlen-1:0] exp_data,
                            input logic [ralen-1:0] exp_dest);
    checks++;
    if (rf_data_o !== exp_data) begin
      errors++;
      $display("Mismatch %s rf_data: expected %h, actual %h", name, exp_data, rf_data_o);
    end
    if (rf_dest_o !== exp_dest) begin
      errors++;
      $display("Mismatch %s rf_dest: expected %0d, actual %0d", name, exp_dest, rf_dest_o);
    end
  endtask

  task automatic check_error(input string name, input string flag_name, input logic flag,
                             input logic [xlen-1:0] exp_addr);
    checks++;
    if (flag !== 1'b1) begin
      errors++;
      $display("%s: %s flag was not raised for address %h", name, flag_name, exp_addr);
    end else if (ctrl_exception_addr_o !== exp_addr) begin
      errors++;
      $display("Mismatch %s exception addr: expected %h, actual %h",
               name, exp_addr, ctrl_exception_addr_o);
    end
  endtask

  task automatic store_cmd(input lsu_cmd_e cmd, input logic [xlen-1:0] addr,
                           input logic [xlen-1:0] data, output int waited);
    send_cmd(make_req(cmd, addr, data, 5'd0), waited);
    model_store(cmd, addr, data);
  endtask

  task automatic load_and_check(input string name, input lsu_cmd_e cmd,
                                input logic [xlen-1:0] addr, input logic [ralen-1:0] dest);
    int waited;
    bit seen;
    send_cmd(make_req(cmd, addr, 32'h0, dest), waited);
    wait_event(ev_wb, 8, seen);
    if (!seen) begin
      errors++;
      $display("%s: no register write-back for load at %h", name, addr);
    end else begin
      check_load(name, model_load(cmd, addr), dest);
    end
  endtask

  task automatic report_test(input string name, input int start);
    $display("%-18s %0d errors", name, errors - start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  // every word gets a value tied to its full address before any read
  task automatic fill_memory();
    logic [xlen-1:0] addr;
    int              waited;
    for (int i = 0; i < ram_depth_words; i++) begin
      addr = 32'(i) << 2;
      store_cmd(lsu_store_word, addr, (addr * 32'h9e3779b1) ^ 32'h3c5a0f96, waited);
    end
  endtask

  task automatic store_load_word();
    int start;
    int waited;
    start = errors;
    store_cmd(lsu_store_word, 32'h40, lcg_next(), waited);
    load_and_check("store_load_word", lsu_load_word, 32'h40, 5'd7);
    // top word of the RAM
    store_cmd(lsu_store_word, 32'h3fc, lcg_next(), waited);
    load_and_check("store_load_word", lsu_load_word, 32'h3fc, 5'd31);
    report_test("store_load_word", start);
  endtask

  task automatic sub_word_lanes();
    int              start;
    int              waited;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    start = errors;
    // one byte per word, a different lane each time
    for (int lane = 0; lane < 4; lane++) begin
      addr    = 32'h80 + 32'(lane * 5);
      data    = lcg_next();
      data[7] = lane[0];
      store_cmd(lsu_store_byte, addr, data, waited);
      load_and_check("sub_word_lanes", lsu_load_word, addr & ~32'h3, 5'(lane + 1));
      load_and_check("sub_word_lanes", lsu_load_byte, addr, 5'(lane + 5));
      load_and_check("sub_word_lanes", lsu_load_byte_u, addr, 5'(lane + 9));
    end
    // halves in the low and high lane pair
    for (int lane = 0; lane < 4; lane += 2) begin
      addr     = 32'ha0 + 32'(lane * 3);
      data     = lcg_next();
      data[15] = !lane[1];
      store_cmd(lsu_store_half, addr, data, waited);
      load_and_check("sub_word_lanes", lsu_load_word, addr & ~32'h3, 5'd20);
      load_and_check("sub_word_lanes", lsu_load_half, addr, 5'd21);
      load_and_check("sub_word_lanes", lsu_load_half_u, addr, 5'd22);
    end
    report_test("sub_word_lanes", start);
  endtask

  task automatic misaligned_one(input lsu_cmd_e cmd, input logic [xlen-1:0] addr);
    int   waited;
    bit   wb_seen;
    logic flag;
    logic other;
    send_cmd(make_req(cmd, addr, lcg_next(), 5'd9), waited);
    // pulse sits in the cycle right after acceptance
    flag  = cmd[3] ? ctrl_misaligned_store_o : ctrl_misaligned_load_o;
    other = cmd[3] ? ctrl_misaligned_load_o : ctrl_misaligned_store_o;
    check_error("misaligned_access", cmd[3] ? "misaligned store" : "misaligned load",
                flag, addr);
    if (other !== 1'b0) begin
      errors++;
      $display("misaligned_access: wrong misaligned flag raised for address %h", addr);
    end
    wb_seen = 1'b0;
    for (int n = 0; n < 4; n++) begin
      @(negedge clk_i);
      if (rf_wb_o) begin
        wb_seen = 1'b1;
      end
    end
    if (wb_seen) begin
      errors++;
      $display("misaligned_access: register write-back after misaligned access at %h", addr);
    end
    // model untouched, so this shows the RAM word is unchanged
    load_and_check("misaligned_access", lsu_load_word, addr & ~32'h3, 5'd10);
  endtask

  task automatic misaligned_access();
    int start;
    start = errors;
    misaligned_one(lsu_load_half, 32'h111);
    misaligned_one(lsu_store_half, 32'h123);
    misaligned_one(lsu_load_word, 32'h142);
    misaligned_one(lsu_store_word, 32'h181);
    misaligned_one(lsu_load_half_u, 32'h1c5);
    misaligned_one(lsu_store_word, 32'h1e3);
    report_test("misaligned_access", start);
  endtask

  task automatic out_of_range();
    int              start;
    int              waited;
    bit              seen;
    logic [xlen-1:0] addr;
    start = errors;
    // first byte past the RAM, aliases word 0 in the low index bits
    addr = 32'(ram_depth_words * 4);
    send_cmd(make_req(lsu_store_word, addr, lcg_next(), 5'd0), waited);
    wait_event(ev_bus_error, 8, seen);
    check_error("out_of_range", "bus error", ctrl_bus_error_o, addr);
    load_and_check("out_of_range", lsu_load_word, 32'h0, 5'd3);
    addr = 32'h8000_0010;
    send_cmd(make_req(lsu_load_word, addr, 32'h0, 5'd4), waited);
    wait_event(ev_bus_error, 8, seen);
    check_error("out_of_range", "bus error", ctrl_bus_error_o, addr);
    if (rf_wb_o !== 1'b0) begin
      errors++;
      $display("out_of_range: register write-back on a failing load");
    end
    wait_event(ev_ready, 4, seen);
    if (!seen) begin
      errors++;
      $display("out_of_range: core still stalled after the failing load");
    end
    report_test("out_of_range", start);
  endtask

  task automatic store_burst();
    int start;
    int waited;
    start = errors;
    for (int n = 0; n < 10; n++) begin
      // two late stores overwrite earlier words, order decides the result
      if (n < 8) begin
        store_cmd(lsu_store_word, 32'h200 + 32'(n * 4), lcg_next(), waited);
      end else begin
        store_cmd(n == 8 ? lsu_store_byte : lsu_store_half,
                  n == 8 ? 32'h201 : 32'h20e, lcg_next(), waited);
      end
      // the first store may still see the end of the previous load
      if (n > 0 && waited != 0) begin
        errors++;
        $display("store_burst: store %0d stalled for %0d cycles", n, waited);
      end
    end
    for (int n = 0; n < 8; n++) begin
      load_and_check("store_burst", lsu_load_word, 32'h200 + 32'(n * 4), 5'(n + 12));
    end
    report_test("store_burst", start);
  endtask

  task automatic random_traffic();
    int              start;
    int              waited;
    logic [31:0]     rnd;
    lsu_cmd_e        cmd;
    logic [xlen-1:0] addr;
    start = errors;
    for (int n = 0; n < 200; n++) begin
      rnd  = lcg_next();
      cmd  = pick_cmd(rnd[2:0]);
      addr = {22'h0, rnd[12:3]};
      // round down to the access size
      if (cmd == lsu_load_word || cmd == lsu_store_word) begin
        addr[1:0] = 2'b00;
      end else if (cmd == lsu_load_half || cmd == lsu_load_half_u || cmd == lsu_store_half) begin
        addr[0] = 1'b0;
      end
      if (cmd == lsu_store_byte || cmd == lsu_store_half || cmd == lsu_store_word) begin
        store_cmd(cmd, addr, lcg_next(), waited);
      end else begin
        load_and_check("random_traffic", cmd, addr, rnd[17:13]);
      end
    end
    report_test("random_traffic", start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rstn_i      = 1'b0;
    lsu_valid_i = 1'b0;
    lsu_req_i   = '0;
    lcg_state   = 32'h5173;
    errors      = 0;
    checks      = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;
    fill_memory();
    store_load_word();
    sub_word_lanes();
    misaligned_access();
    out_of_range();
    store_burst();
    random_traffic();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, tests did not finish", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- sim.f
source/lsu_pkg.sv
source/lsu_skid_buffer.sv
source/lsu_issue.sv
source/lsu_data_ram.sv
source/lsu_retire.sv
source/lsu_top.sv
verif/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the LSU testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module lsu_tb -f sim.f -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
